//--- hw/imuldiv_defines.svh
// width and iteration macros for the integer multiply/divide unit
// shared by the package, the RTL and the testbench

`ifndef IMULDIV_DEFINES_SVH
`define IMULDIV_DEFINES_SVH

// ----------------------------------------------------------------------
// operand and result sizes
// ----------------------------------------------------------------------

// operand width, both request operands
`define IMULDIV_XLEN 32

// result width, two operand words side by side
`define IMULDIV_RLEN 64

// one shift step per operand bit, for mul and for div
`define IMULDIV_ITERS 32

`endif

//--- hw/imuldiv_pkg.sv
// function code and result word types for the multiply/divide unit
// result_u decodes one 64-bit word as div or as product

`include "imuldiv_defines.svh"

package imuldiv_pkg;

  // function code carried on the request port
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } fn_t;

  // divide view, remainder on top and quotient below
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0] rem;
    logic [`IMULDIV_XLEN-1:0] quo;
  } div_result_t;

  // product view, plain high and low words
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0] hi;
    logic [`IMULDIV_XLEN-1:0] lo;
  } prod_result_t;

  // same bits, two readings
  typedef union packed {
    div_result_t  div;
    prod_result_t prod;
  } result_u;

endpackage

//--- hw/imuldiv_div_ctrl.sv
// divider control FSM
// drives datapath enables and mux selects plus the val/rdy handshake

`timescale 1ns/1ps

module imuldiv_div_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  imuldiv_pkg::fn_t   req_fn,
  input  logic               req_val,
  output logic               req_rdy,
  output logic               resp_val,
  input  logic               resp_rdy,
  input  logic               sub_msb,
  input  logic               counter_is_zero,
  output logic               is_signed,
  output logic               a_en,
  output logic               b_en,
  output logic               a_mux_sel,
  output logic               sub_mux_sel,
  output logic               cntr_mux_sel,
  output logic               sign_en,
  output logic               rem_sign_mux_sel,
  output logic               div_sign_mux_sel
);

  typedef enum logic [1:0] {IDLE, CALC, DONE} state_t;

  state_t state;
  state_t state_next;
  logic   signed_reg;
  logic   fn_signed;
  logic   req_go;
  logic   resp_go;

  // only div is signed, divu takes the operands as they are
  assign fn_signed = (req_fn == imuldiv_pkg::FN_DIV);
  assign req_go    = req_val & req_rdy;
  assign resp_go   = resp_val & resp_rdy;

  // ----------------------------------------------------------------------
  // state and stored signedness
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      signed_reg <= 1'b0;
    end else begin
      state <= state_next;
      // signedness is fixed for the whole operation
      if (req_go) begin
        signed_reg <= fn_signed;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (req_go) state_next = CALC;
      // counter hits zero on the last shift-subtract
      CALC: if (counter_is_zero) state_next = DONE;
      DONE: if (resp_go) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // control outputs, decoded from state
  // ----------------------------------------------------------------------

  always_comb begin
    req_rdy          = 1'b0;
    resp_val         = 1'b0;
    is_signed        = signed_reg;
    a_en             = 1'b0;
    b_en             = 1'b0;
    a_mux_sel        = 1'b0;
    sub_mux_sel      = 1'b0;
    cntr_mux_sel     = 1'b0;
    sign_en          = 1'b0;
    rem_sign_mux_sel = 1'b0;
    div_sign_mux_sel = 1'b0;
    case (state)
      IDLE: begin
        // req_rdy is high here, so req_val alone means acceptance
        req_rdy   = 1'b1;
        is_signed = fn_signed;
        a_en      = req_val;
        b_en      = req_val;
        sign_en   = req_val;
      end
      CALC: begin
        a_en         = 1'b1;
        a_mux_sel    = 1'b1;
        // negative difference means restore the shifted value
        sub_mux_sel  = sub_msb;
        cntr_mux_sel = 1'b1;
      end
      DONE: begin
        resp_val         = 1'b1;
        // datapath applies these only where its stored sign bit is set
        rem_sign_mux_sel = signed_reg;
        div_sign_mux_sel = signed_reg;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/imuldiv_div_dpath.sv
// divider datapath: remainder/quotient register, divisor, step counter
// restoring shift-subtract and output sign correction

`timescale 1ns/1ps
`include "imuldiv_defines.svh"

module imuldiv_div_dpath (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`IMULDIV_XLEN-1:0]  req_a,
  input  logic [`IMULDIV_XLEN-1:0]  req_b,
  input  logic                      is_signed,
  input  logic                      a_en,
  input  logic                      b_en,
  input  logic                      a_mux_sel,
  input  logic                      sub_mux_sel,
  input  logic                      cntr_mux_sel,
  input  logic                      sign_en,
  input  logic                      rem_sign_mux_sel,
  input  logic                      div_sign_mux_sel,
  output logic                      sub_msb,
  output logic                      counter_is_zero,
  output imuldiv_pkg::result_u      result
);

  localparam int XLEN = `IMULDIV_XLEN;
  localparam int WLEN = `IMULDIV_RLEN + 1;
  localparam int CW   = $clog2(`IMULDIV_ITERS);

  logic [WLEN-1:0] a_reg;
  logic [XLEN-1:0] b_reg;
  logic [CW-1:0]   cntr_reg;
  logic            quo_sign_reg;
  logic            rem_sign_reg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic [XLEN-1:0] a_in;
  logic [XLEN-1:0] b_in;
  logic [WLEN-1:0] a_init;
  logic [WLEN-1:0] a_shift;
  logic [WLEN-1:0] sub_out;
  logic [WLEN-1:0] sub_sel;
  logic [WLEN-1:0] a_next;
  logic [CW-1:0]   cntr_next;
  logic [XLEN-1:0] quo_raw;
  logic [XLEN-1:0] rem_raw;

  // ----------------------------------------------------------------------
  // operand magnitudes, only for signed div
  // ----------------------------------------------------------------------

  assign a_mag  = req_a[XLEN-1] ? -req_a : req_a;
  assign b_mag  = req_b[XLEN-1] ? -req_b : req_b;
  assign a_in   = is_signed ? a_mag : req_a;
  assign b_in   = is_signed ? b_mag : req_b;
  // dividend starts in the low word, upper bits clear
  assign a_init = {{(WLEN-XLEN){1'b0}}, a_in};

  // ----------------------------------------------------------------------
  // one shift-subtract step
  // ----------------------------------------------------------------------

  assign a_shift = a_reg << 1;
  // divisor lines up with the remainder half
  assign sub_out = a_shift - {1'b0, b_reg, {XLEN{1'b0}}};
  assign sub_msb = sub_out[WLEN-1];

  // restore drops the difference and shifts in a zero quotient bit
  assign sub_sel = sub_mux_sel ? {a_shift[WLEN-1:1], 1'b0}
                               : {sub_out[WLEN-1:1], 1'b1};
  assign a_next  = a_mux_sel ? sub_sel : a_init;

  // down counter, reloaded with iters-1 outside CALC
  assign cntr_next       = cntr_mux_sel ? cntr_reg - CW'(1) : CW'(`IMULDIV_ITERS - 1);
  assign counter_is_zero = (cntr_reg == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      cntr_reg <= CW'(`IMULDIV_ITERS - 1);
    end else begin
      cntr_reg <= cntr_next;
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= b_in;
    end
    // quotient sign from both operands, remainder follows the dividend
    if (sign_en) begin
      quo_sign_reg <= req_a[XLEN-1] ^ req_b[XLEN-1];
      rem_sign_reg <= req_a[XLEN-1];
    end
  end

  // ----------------------------------------------------------------------
  // sign correction at the output
  // ----------------------------------------------------------------------

  assign quo_raw = a_reg[XLEN-1:0];
  assign rem_raw = a_reg[2*XLEN-1:XLEN];

  always_comb begin
    result.div.quo = (div_sign_mux_sel & quo_sign_reg) ? -quo_raw : quo_raw;
    result.div.rem = (rem_sign_mux_sel & rem_sign_reg) ? -rem_raw : rem_raw;
  end

endmodule

//--- hw/imuldiv_mul_iterative.sv
// iterative shift-and-add multiplier with its own FSM
// signed 32x32 giving all 64 product bits

`timescale 1ns/1ps
`include "imuldiv_defines.svh"

module imuldiv_mul_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  output logic                      req_rdy,
  input  imuldiv_pkg::fn_t          req_fn,
  input  logic [`IMULDIV_XLEN-1:0]  req_a,
  input  logic [`IMULDIV_XLEN-1:0]  req_b,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output imuldiv_pkg::result_u      resp_result
);

  localparam int XLEN = `IMULDIV_XLEN;
  localparam int RLEN = `IMULDIV_RLEN;
  localparam int CW   = $clog2(`IMULDIV_ITERS);

  typedef enum logic [1:0] {IDLE, CALC, DONE} state_t;

  state_t          state;
  state_t          state_next;
  logic [RLEN-1:0] mcand_reg;
  logic [XLEN-1:0] mplier_reg;
  logic [RLEN-1:0] prod_reg;
  logic [CW-1:0]   cntr_reg;
  logic            neg_reg;
  logic            fn_signed;
  logic            req_go;
  logic            resp_go;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic [RLEN-1:0] prod_fin;

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign req_go   = req_val & req_rdy;
  assign resp_go  = resp_val & resp_rdy;

  // mul is the only code routed here, and it is signed
  assign fn_signed = (req_fn == imuldiv_pkg::FN_MUL);
  assign a_mag     = (fn_signed & req_a[XLEN-1]) ? -req_a : req_a;
  assign b_mag     = (fn_signed & req_b[XLEN-1]) ? -req_b : req_b;

  // ----------------------------------------------------------------------
  // FSM and step counter
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (req_go) state_next = CALC;
      CALC: if (cntr_reg == '0) state_next = DONE;
      // result held until the response transfers
      DONE: if (resp_go) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      cntr_reg <= CW'(`IMULDIV_ITERS - 1);
    end else begin
      state <= state_next;
      if (req_go) begin
        cntr_reg <= CW'(`IMULDIV_ITERS - 1);
      end else if (state == CALC) begin
        cntr_reg <= cntr_reg - CW'(1);
      end
    end
  end

  // ----------------------------------------------------------------------
  // shift-and-add on magnitudes
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand_reg  <= {{(RLEN-XLEN){1'b0}}, a_mag};
      mplier_reg <= b_mag;
      prod_reg   <= '0;
      neg_reg    <= fn_signed & (req_a[XLEN-1] ^ req_b[XLEN-1]);
    end else if (state == CALC) begin
      // add the multiplicand for each set multiplier bit
      if (mplier_reg[0]) begin
        prod_reg <= prod_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // sign fix on the full 64-bit product
  assign prod_fin = neg_reg ? -prod_reg : prod_reg;

  always_comb begin
    resp_result.prod.hi = prod_fin[RLEN-1:XLEN];
    resp_result.prod.lo = prod_fin[XLEN-1:0];
  end

endmodule

//--- hw/imuldiv_dispatch.sv
// request router between the divider and the multiplier
// two-entry order queue keeps responses in request order

`timescale 1ns/1ps

module imuldiv_dispatch (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_val,
  output logic                  req_rdy,
  input  imuldiv_pkg::fn_t      req_fn,
  output logic                  div_req_val,
  input  logic                  div_req_rdy,
  output logic                  mul_req_val,
  input  logic                  mul_req_rdy,
  input  logic                  div_resp_val,
  output logic                  div_resp_rdy,
  input  imuldiv_pkg::result_u  div_resp_result,
  input  logic                  mul_resp_val,
  output logic                  mul_resp_rdy,
  input  imuldiv_pkg::result_u  mul_resp_result,
  output logic                  resp_val,
  input  logic                  resp_rdy,
  output imuldiv_pkg::result_u  resp_result
);

  // tag 1 is the divider, tag 0 the multiplier
  logic [1:0] tag_q;
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       full;
  logic       empty;
  logic       req_is_div;
  logic       head_is_div;
  logic       push;
  logic       pop;

  assign full        = (count == 2'd2);
  assign empty       = (count == 2'd0);
  assign req_is_div  = (req_fn != imuldiv_pkg::FN_MUL);
  assign head_is_div = tag_q[rd_ptr];

  // ----------------------------------------------------------------------
  // request side, no state of its own
  // ----------------------------------------------------------------------

  assign req_rdy     = ~full & (req_is_div ? div_req_rdy : mul_req_rdy);
  assign div_req_val = req_val & ~full & req_is_div;
  assign mul_req_val = req_val & ~full & ~req_is_div;
  assign push        = req_val & req_rdy;

  // ----------------------------------------------------------------------
  // response side, only the queue head reaches the port
  // ----------------------------------------------------------------------

  assign resp_val     = ~empty & (head_is_div ? div_resp_val : mul_resp_val);
  assign resp_result  = head_is_div ? div_resp_result : mul_resp_result;
  assign div_resp_rdy = resp_rdy & ~empty & head_is_div;
  assign mul_resp_rdy = resp_rdy & ~empty & ~head_is_div;
  assign pop          = resp_val & resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  // queue storage
  always_ff @(posedge clk) begin
    if (push) begin
      tag_q[wr_ptr] <= req_is_div;
    end
  end

endmodule

//--- hw/imuldiv_unit.sv
// multiply/divide unit top level
// dispatcher, divider control and datapath, iterative multiplier

`timescale 1ns/1ps
`include "imuldiv_defines.svh"

module imuldiv_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  output logic                      req_rdy,
  input  imuldiv_pkg::fn_t          req_fn,
  input  logic [`IMULDIV_XLEN-1:0]  req_a,
  input  logic [`IMULDIV_XLEN-1:0]  req_b,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output imuldiv_pkg::result_u      resp_result
);

  // unit handshakes
  logic div_req_val, div_req_rdy, div_resp_val, div_resp_rdy;
  logic mul_req_val, mul_req_rdy, mul_resp_val, mul_resp_rdy;
  imuldiv_pkg::result_u div_resp_result;
  imuldiv_pkg::result_u mul_resp_result;

  // divider control to datapath
  logic is_signed, a_en, b_en, a_mux_sel, sub_mux_sel, cntr_mux_sel;
  logic sign_en, rem_sign_mux_sel, div_sign_mux_sel;
  logic sub_msb, counter_is_zero;

  imuldiv_dispatch dispatch (
    .clk, .reset, .req_val, .req_rdy, .req_fn,
    .div_req_val, .div_req_rdy, .mul_req_val, .mul_req_rdy,
    .div_resp_val, .div_resp_rdy, .div_resp_result,
    .mul_resp_val, .mul_resp_rdy, .mul_resp_result,
    .resp_val, .resp_rdy, .resp_result
  );

  imuldiv_div_ctrl div_ctrl (
    .clk, .reset, .req_fn,
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .sub_msb, .counter_is_zero, .is_signed,
    .a_en, .b_en, .a_mux_sel, .sub_mux_sel, .cntr_mux_sel,
    .sign_en, .rem_sign_mux_sel, .div_sign_mux_sel
  );

  // operands fan out unchanged to both units
  imuldiv_div_dpath div_dpath (
    .clk, .reset, .req_a, .req_b, .is_signed,
    .a_en, .b_en, .a_mux_sel, .sub_mux_sel, .cntr_mux_sel,
    .sign_en, .rem_sign_mux_sel, .div_sign_mux_sel,
    .sub_msb, .counter_is_zero,
    .result   (div_resp_result)
  );

  imuldiv_mul_iterative mul (
    .clk, .reset, .req_fn, .req_a, .req_b,
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_resp_result)
  );

endmodule

//--- bench/imuldiv_vectors.svh
// stimulus and expected results for the multiply/divide testbench
// columns: fn, a, b, expected word ({rem, quo} for div, {hi, lo} for mul)

`ifndef IMULDIV_VECTORS_SVH
`define IMULDIV_VECTORS_SVH

task load_vectors;
  begin
    // first part alternates div and mul so both units overlap
    add_vec(imuldiv_pkg::FN_DIVU, 32'h0000_0064, 32'h0000_0007, 64'h00000002_0000000e);
    add_vec(imuldiv_pkg::FN_MUL,  32'h0000_0003, 32'h0000_0005, 64'h00000000_0000000f);
    add_vec(imuldiv_pkg::FN_DIVU, 32'hffff_ffff, 32'h0000_0010, 64'h0000000f_0fffffff);
    add_vec(imuldiv_pkg::FN_MUL,  32'hffff_fffd, 32'h0000_0005, 64'hffffffff_fffffff1);
    // signed div, all four sign pairs of 7 and 2
    add_vec(imuldiv_pkg::FN_DIV,  32'hffff_fff9, 32'h0000_0002, 64'hffffffff_fffffffd);
    add_vec(imuldiv_pkg::FN_MUL,  32'hffff_fffd, 32'hffff_fffb, 64'h00000000_0000000f);
    add_vec(imuldiv_pkg::FN_DIV,  32'h0000_0007, 32'hffff_fffe, 64'h00000001_fffffffd);
    add_vec(imuldiv_pkg::FN_MUL,  32'h0000_0000, 32'hffff_ffff, 64'h00000000_00000000);
    add_vec(imuldiv_pkg::FN_DIV,  32'hffff_fff9, 32'hffff_fffe, 64'hffffffff_00000003);
    // most negative value squared
    add_vec(imuldiv_pkg::FN_MUL,  32'h8000_0000, 32'h8000_0000, 64'h40000000_00000000);
    // most negative dividend over 1 and -1, quotient wraps
    add_vec(imuldiv_pkg::FN_DIV,  32'h8000_0000, 32'h0000_0001, 64'h00000000_80000000);
    add_vec(imuldiv_pkg::FN_MUL,  32'h7fff_ffff, 32'h7fff_ffff, 64'h3fffffff_00000001);
    add_vec(imuldiv_pkg::FN_DIV,  32'h8000_0000, 32'hffff_ffff, 64'h00000000_80000000);
    add_vec(imuldiv_pkg::FN_MUL,  32'h1234_5678, 32'h0000_0010, 64'h00000001_23456780);
    // divide by zero, negative dividend flips the all-ones quotient
    add_vec(imuldiv_pkg::FN_DIV,  32'hffff_ff9c, 32'h0000_0000, 64'hffffff9c_00000001);
    add_vec(imuldiv_pkg::FN_MUL,  32'h8000_0000, 32'h7fff_ffff, 64'hc0000000_80000000);
    add_vec(imuldiv_pkg::FN_DIVU, 32'h0000_abcd, 32'h0000_0000, 64'h0000abcd_ffffffff);
    add_vec(imuldiv_pkg::FN_MUL,  32'hffff_ffff, 32'hffff_ffff, 64'h00000000_00000001);
    add_vec(imuldiv_pkg::FN_DIV,  32'h0000_0064, 32'h0000_0000, 64'h00000064_ffffffff);
    add_vec(imuldiv_pkg::FN_MUL,  32'h0001_0000, 32'hffff_0000, 64'hffffffff_00000000);
    // remaining divides run back to back
    add_vec(imuldiv_pkg::FN_DIVU, 32'h1234_5678, 32'h0000_1000, 64'h00000678_00012345);
    add_vec(imuldiv_pkg::FN_DIVU, 32'h0000_0005, 32'h0000_0009, 64'h00000005_00000000);
    add_vec(imuldiv_pkg::FN_DIVU, 32'h8000_0000, 32'h0000_0003, 64'h00000002_2aaaaaaa);
    add_vec(imuldiv_pkg::FN_DIVU, 32'hffff_ffff, 32'hffff_ffff, 64'h00000000_00000001);
    add_vec(imuldiv_pkg::FN_DIVU, 32'h8000_0000, 32'h0000_0000, 64'h80000000_ffffffff);
    add_vec(imuldiv_pkg::FN_DIV,  32'h0000_0007, 32'h0000_0002, 64'h00000001_00000003);
    add_vec(imuldiv_pkg::FN_DIV,  32'hffff_fc18, 32'h0000_0007, 64'hfffffffa_ffffff72);
    add_vec(imuldiv_pkg::FN_DIV,  32'h8000_0000, 32'h7fff_ffff, 64'hffffffff_ffffffff);
  end
endtask

`endif

//--- bench/imuldiv_tb.sv
// testbench for the multiply/divide unit
// table-driven requests, random response back-pressure, in-order checks

`timescale 1ns/1ps
`include "imuldiv_defines.svh"

module imuldiv_tb;

  // cycle budget per table entry, plus room for back-pressure stalls
  localparam int CYCLES_PER_ENTRY = 40;
  localparam int STALL_PER_ENTRY  = 8;
  localparam int EXTRA_CYCLES     = 100;

  logic                      clk;
  logic                      reset;
  logic                      req_val;
  logic                      req_rdy;
  imuldiv_pkg::fn_t          req_fn;
  logic [`IMULDIV_XLEN-1:0]  req_a;
  logic [`IMULDIV_XLEN-1:0]  req_b;
  logic                      resp_val;
  logic                      resp_rdy;
  imuldiv_pkg::result_u      resp_result;

  // stimulus table
  imuldiv_pkg::fn_t          vec_fn[$];
  logic [`IMULDIV_XLEN-1:0]  vec_a[$];
  logic [`IMULDIV_XLEN-1:0]  vec_b[$];
  logic [`IMULDIV_RLEN-1:0]  vec_exp[$];

  int                        num_vec;
  int                        req_idx;
  int                        resp_idx;
  int                        inflight;
  int                        overlap_count;
  int                        value_errors;
  int                        other_errors;
  int                        cycle_count;
  int                        cycle_limit;
  logic [31:0]               lfsr;
  logic                      held;
  imuldiv_pkg::result_u      held_result;

  imuldiv_unit dut (
    .clk, .reset, .req_val, .req_rdy, .req_fn, .req_a, .req_b,
    .resp_val, .resp_rdy, .resp_result
  );

  always #50 clk = ~clk;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  task add_vec(input imuldiv_pkg::fn_t fn, input logic [31:0] a, input logic [31:0] b,
               input logic [63:0] exp_word);
    begin
      vec_fn.push_back(fn);
      vec_a.push_back(a);
      vec_b.push_back(b);
      vec_exp.push_back(exp_word);
    end
  endtask

  `include "imuldiv_vectors.svh"

  // galois form, shifts right, one step per bit taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    begin
      n = s >> 1;
      if (s[0]) begin
        n = n ^ 32'ha300_0000;
      end
      lfsr_next = n;
    end
  endfunction

  task check_response(input int idx, input imuldiv_pkg::result_u got);
    imuldiv_pkg::result_u exp_res;
    logic [63:0]          rebuilt;
    begin
      exp_res = vec_exp[idx];
      if (vec_fn[idx] == imuldiv_pkg::FN_MUL) begin
        if (got.prod.hi !== exp_res.prod.hi) begin
          $display("Fail resp_result.prod.hi entry %0d: got %h expected %h",
                   idx, got.prod.hi, exp_res.prod.hi);
          value_errors++;
        end
        if (got.prod.lo !== exp_res.prod.lo) begin
          $display("Fail resp_result.prod.lo entry %0d: got %h expected %h",
                   idx, got.prod.lo, exp_res.prod.lo);
          value_errors++;
        end
      end else begin
        if (got.div.rem !== exp_res.div.rem) begin
          $display("Fail resp_result.div.rem entry %0d: got %h expected %h",
                   idx, got.div.rem, exp_res.div.rem);
          value_errors++;
        end
        if (got.div.quo !== exp_res.div.quo) begin
          $display("Fail resp_result.div.quo entry %0d: got %h expected %h",
                   idx, got.div.quo, exp_res.div.quo);
          value_errors++;
        end
        // unsigned: quo * b + rem must give back a, with rem below b
        if (vec_fn[idx] == imuldiv_pkg::FN_DIVU && vec_b[idx] != 0) begin
          rebuilt = {32'b0, got.div.quo} * {32'b0, vec_b[idx]} + {32'b0, got.div.rem};
          if (rebuilt !== {32'b0, vec_a[idx]} || got.div.rem >= vec_b[idx]) begin
            $display("divu entry %0d: quotient and remainder do not rebuild the dividend",
                     idx);
            other_errors++;
          end
        end
      end
    end
  endtask

  task finish_run;
    begin
      $display("responses %0d of %0d, overlaps %0d, value errors %0d, other errors %0d",
               resp_idx, num_vec, overlap_count, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  endtask

  // ----------------------------------------------------------------------
  // run limit
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, only %0d of %0d responses arrived",
               cycle_count, resp_idx, num_vec);
      other_errors++;
      finish_run();
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    req_val       = 1'b0;
    req_fn        = imuldiv_pkg::FN_MUL;
    req_a         = '0;
    req_b         = '0;
    resp_rdy      = 1'b0;
    lfsr          = 32'd75715;
    req_idx       = 0;
    resp_idx      = 0;
    overlap_count = 0;
    value_errors  = 0;
    other_errors  = 0;
    cycle_count   = 0;
    held          = 1'b0;
    held_result   = '0;
    load_vectors();
    num_vec     = vec_a.size();
    cycle_limit = num_vec * (CYCLES_PER_ENTRY + STALL_PER_ENTRY) + EXTRA_CYCLES;

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #10;
    // empty queue and idle units right after reset
    if (resp_val !== 1'b0) begin
      $display("resp_val is high right after reset");
      other_errors++;
    end
    if (req_rdy !== 1'b1) begin
      $display("req_rdy is low right after reset");
      other_errors++;
    end

    while (resp_idx < num_vec) begin
      @(negedge clk);
      // request held steady until it transfers
      if (req_idx < num_vec) begin
        req_val = 1'b1;
        req_fn  = vec_fn[req_idx];
        req_a   = vec_a[req_idx];
        req_b   = vec_b[req_idx];
      end else begin
        req_val = 1'b0;
      end
      lfsr     = lfsr_next(lfsr);
      resp_rdy = lfsr[0];

      // outputs are settled here until the next rising edge
      #10;
      inflight = req_idx - resp_idx;
      if (held) begin
        if (resp_val !== 1'b1) begin
          $display("resp_val fell before the held response was accepted");
          other_errors++;
        end else if (resp_result !== held_result) begin
          $display("Fail resp_result held: got %h expected %h", resp_result, held_result);
          value_errors++;
        end
      end
      if (resp_val === 1'b1 && resp_rdy) begin
        if (inflight == 0) begin
          $display("response appeared with no request outstanding");
          other_errors++;
        end else begin
          check_response(resp_idx, resp_result);
          resp_idx++;
        end
      end
      held        = (resp_val === 1'b1) && !resp_rdy;
      held_result = resp_result;
      if (req_val && req_rdy === 1'b1) begin
        // accepted while an earlier operation is still in flight
        if (inflight > 0) begin
          overlap_count++;
        end
        req_idx++;
      end
    end

    // nothing more may come out after the last entry
    repeat (40) begin
      @(negedge clk);
      req_val  = 1'b0;
      resp_rdy = 1'b1;
      #10;
      if (resp_val !== 1'b0) begin
        $display("extra response after the last table entry");
        other_errors++;
      end
    end

    if (overlap_count == 0) begin
      $display("no request was accepted while another operation was in flight");
      other_errors++;
    end
    finish_run();
  end

endmodule

//--- project.f
+incdir+hw
+incdir+bench
hw/imuldiv_pkg.sv
hw/imuldiv_div_ctrl.sv
hw/imuldiv_div_dpath.sv
hw/imuldiv_mul_iterative.sv
hw/imuldiv_dispatch.sv
hw/imuldiv_unit.sv
bench/imuldiv_tb.sv
